//--- gb2p_glue.f
gb2p_cfg_pkg.sv
gb2p_bus_pkg.sv
rom_store.sv
rom_arbiter.sv
cart_rom_port.sv
download_router.sv
audio_mixer.sv
gb2p_glue.sv
gb2p_glue_tb.sv

//--- Bender.yml
package:
  name: gb2p_glue

sources:
  - gb2p_cfg_pkg.sv
  - gb2p_bus_pkg.sv
  - rom_store.sv
  - rom_arbiter.sv
  - cart_rom_port.sv
  - download_router.sv
  - audio_mixer.sv
  - gb2p_glue.sv
  - target: test
    files:
      - gb2p_glue_tb.sv

//--- gb2p_glue_tb.sv
/*
 * Testbench of the two-console glue, built with a 64-word store.
 * Stimulus comes from an LFSR and expected values come from models kept here.
 */
module gb2p_glue_tb;

	localparam int aw = 6;
	localparam int words = 2 ** aw;
	localparam int wait_limit = 200;
	localparam logic [127:0] pal_reset = 128'h8282_1451_7356_305A_5F1A_3B49_0000_0000;

	logic                      clk_sys;
	logic                      reset;
	logic                      dl_active;
	gb2p_bus_pkg::dl_beat_t    dl;
	logic                      rd1;
	logic                      rd2;
	logic [aw:0]               addr1;
	logic [aw:0]               addr2;
	logic [7:0]                data1;
	logic [7:0]                data2;
	logic                      valid1;
	logic                      valid2;
	logic                      core_hold;
	gb2p_bus_pkg::stereo_t     audio1;
	gb2p_bus_pkg::stereo_t     audio2;
	gb2p_cfg_pkg::audio_mode_e audio_mode;
	gb2p_bus_pkg::stereo_t     audio_out;
	gb2p_bus_pkg::pal_t        palette;

	// Models and bookkeeping
	logic [31:0]  lfsr;
	logic [15:0]  rom_model [words];
	logic [127:0] pal_model;
	int           err_count;
	int           check_count;
	int           errs_at_start;
	int           tests_run;
	int           tests_failed;

	gb2p_glue #(.rom_aw(aw)) dut_i (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.dl_active  (dl_active),
		.dl         (dl),
		.rd1        (rd1),
		.rd2        (rd2),
		.addr1      (addr1),
		.addr2      (addr2),
		.data1      (data1),
		.data2      (data2),
		.valid1     (valid1),
		.valid2     (valid2),
		.core_hold  (core_hold),
		.audio1     (audio1),
		.audio2     (audio2),
		.audio_mode (audio_mode),
		.audio_out  (audio_out),
		.palette    (palette)
	);

	always #20 clk_sys = ~clk_sys;

	//////////////////////////////////////////////////////////////////////
	// Models
	//////////////////////////////////////////////////////////////////////

	// Fibonacci LFSR with taps 32 22 2 1, one step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] val;
		logic        fb;
		val = '0;
		for (int i = 0; i < n; i++) begin
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			val  = {val[30:0], fb};
		end
		return val;
	endfunction

	// Even byte is the low half of the word
	function automatic logic [7:0] model_byte(input logic [aw:0] a);
		logic [15:0] w;
		w = rom_model[a[aw:1]];
		return a[0] ? w[15:8] : w[7:0];
	endfunction

	function automatic gb2p_bus_pkg::stereo_t model_mix(input logic [1:0] mode,
			input gb2p_bus_pkg::stereo_t c1, input gb2p_bus_pkg::stereo_t c2);
		gb2p_bus_pkg::stereo_t m;
		case (mode)
			2'd0: m = c1;
			2'd1: m = c2;
			2'd2: begin
				m.left  = (c1.left >> 1) + (c2.left >> 1);
				m.right = (c1.right >> 1) + (c2.right >> 1);
			end
			default: begin
				m.left  = (c1.left >> 1) + (c1.right >> 1);
				m.right = (c2.left >> 1) + (c2.right >> 1);
			end
		endcase
		return m;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Checks and bus helpers
	//////////////////////////////////////////////////////////////////////

	task automatic compare(input string name, input logic [127:0] expected,
			input logic [127:0] actual);
		check_count++;
		if (actual !== expected) begin
			err_count++;
			$display("FAILED at time %0t: %s expected %0h actual %0h",
				$time, name, expected, actual);
		end
	endtask

	task automatic start_test();
		errs_at_start = err_count;
	endtask

	task automatic report_test(input string name);
		tests_run++;
		if (err_count == errs_at_start) begin
			$display("test %0d %s: ok", tests_run, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: %0d errors", tests_run, name, err_count - errs_at_start);
		end
	endtask

	// Waits on negative edges for the port's valid pulse
	task automatic wait_valid(input int port, output logic [7:0] got, output logic ok);
		int n;
		n   = 0;
		ok  = 1'b0;
		got = '0;
		while (!ok && n < wait_limit) begin
			if ((port == 1) ? valid1 : valid2) begin
				ok  = 1'b1;
				got = (port == 1) ? data1 : data2;
			end else begin
				@(negedge clk_sys);
				n++;
			end
		end
		if (!ok) begin
			err_count++;
			$display("Timeout: port %0d never raised valid", port);
		end
	endtask

	task automatic read_single(input int port, input logic [aw:0] a);
		logic [7:0] got;
		logic       ok;
		@(negedge clk_sys);
		if (port == 1) begin
			rd1   = 1'b1;
			addr1 = a;
		end else begin
			rd2   = 1'b1;
			addr2 = a;
		end
		@(negedge clk_sys);
		rd1 = 1'b0;
		rd2 = 1'b0;
		wait_valid(port, got, ok);
		if (ok) begin
			compare((port == 1) ? "data1" : "data2", model_byte(a), got);
		end
	endtask

	// Both ports strobe together, each pulse is caught on its own
	task automatic read_both(input logic [aw:0] a1, input logic [aw:0] a2);
		int         n;
		logic       seen1;
		logic       seen2;
		logic [7:0] got1;
		logic [7:0] got2;
		@(negedge clk_sys);
		rd1   = 1'b1;
		rd2   = 1'b1;
		addr1 = a1;
		addr2 = a2;
		@(negedge clk_sys);
		rd1   = 1'b0;
		rd2   = 1'b0;
		n     = 0;
		seen1 = 1'b0;
		seen2 = 1'b0;
		got1  = '0;
		got2  = '0;
		while (!(seen1 && seen2) && n < wait_limit) begin
			if (valid1 && !seen1) begin
				seen1 = 1'b1;
				got1  = data1;
			end
			if (valid2 && !seen2) begin
				seen2 = 1'b1;
				got2  = data2;
			end
			if (!(seen1 && seen2)) begin
				@(negedge clk_sys);
				n++;
			end
		end
		if (!(seen1 && seen2)) begin
			err_count++;
			$display("Timeout: contended read finished on port 1 %0b, port 2 %0b", seen1, seen2);
		end else begin
			compare("data1", model_byte(a1), got1);
			compare("data2", model_byte(a2), got2);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		logic [aw:0]           held_addr;
		logic [7:0]            got;
		logic                  ok;
		logic [15:0]           beat;
		gb2p_bus_pkg::stereo_t s1;
		gb2p_bus_pkg::stereo_t s2;

		lfsr          = 32'h2e54_63d0;
		err_count     = 0;
		check_count   = 0;
		errs_at_start = 0;
		tests_run     = 0;
		tests_failed  = 0;
		pal_model     = pal_reset;
		clk_sys       = 1'b0;
		reset         = 1'b1;
		rd1           = 1'b0;
		rd2           = 1'b0;
		addr1         = '0;
		addr2         = '0;
		audio_mode    = gb2p_cfg_pkg::mode_core1;
		// Outputs must hold their reset values even with live inputs
		dl_active     = 1'b1;
		dl            = '0;
		dl.idx        = 8'h41;
		audio1        = rand_bits(32);
		audio2        = rand_bits(32);
		repeat (5) @(negedge clk_sys);

		start_test();
		compare("valid1", 1'b0, valid1);
		compare("valid2", 1'b0, valid2);
		compare("core_hold", 1'b0, core_hold);
		compare("audio_out", '0, audio_out);
		compare("palette", pal_reset[127:32], palette);
		reset     = 1'b0;
		dl_active = 1'b0;
		dl        = '0;
		report_test("reset state");
		@(negedge clk_sys);

		// Cartridge image with a read parked behind the hold
		start_test();
		@(negedge clk_sys);
		dl_active = 1'b1;
		dl.idx    = 8'h41;
		for (int i = 0; i < words; i++) begin
			@(negedge clk_sys);
			compare("core_hold", 1'b1, core_hold);
			compare("valid1", 1'b0, valid1);
			dl.wr        = 1'b1;
			dl.addr      = 25'(2 * i);
			dl.data      = rand_bits(16);
			rom_model[i] = dl.data;
			if (i == 4) begin
				held_addr = rand_bits(aw + 1);
				addr1     = held_addr;
				rd1       = 1'b1;
			end else begin
				rd1 = 1'b0;
			end
		end
		@(negedge clk_sys);
		compare("core_hold", 1'b1, core_hold);
		compare("valid1", 1'b0, valid1);
		dl_active = 1'b0;
		dl        = '0;
		@(negedge clk_sys);
		compare("core_hold", 1'b0, core_hold);
		wait_valid(1, got, ok);
		if (ok) begin
			compare("data1", model_byte(held_addr), got);
		end
		report_test("cartridge download");

		start_test();
		for (int k = 0; k < 16; k++) begin
			read_single(1, rand_bits(aw + 1));
		end
		for (int k = 0; k < 16; k++) begin
			read_single(2, rand_bits(aw + 1));
		end
		report_test("single-port reads");

		start_test();
		for (int k = 0; k < 24; k++) begin
			read_both(rand_bits(aw + 1), rand_bits(aw + 1));
		end
		report_test("contention");

		// Ten beats push the default fully out of the visible entries
		start_test();
		@(negedge clk_sys);
		dl_active = 1'b1;
		dl.idx    = 8'h03;
		for (int i = 0; i < 10; i++) begin
			@(negedge clk_sys);
			compare("palette", pal_model[127:32], palette);
			compare("core_hold", 1'b0, core_hold);
			beat      = rand_bits(16);
			dl.wr     = 1'b1;
			dl.addr   = 25'(2 * i);
			dl.data   = beat;
			pal_model = {pal_model[111:0], beat[7:0], beat[15:8]};
		end
		@(negedge clk_sys);
		dl_active = 1'b0;
		dl        = '0;
		compare("palette", pal_model[127:32], palette);
		report_test("palette download");

		start_test();
		for (int m = 0; m < 4; m++) begin
			for (int k = 0; k < 8; k++) begin
				@(negedge clk_sys);
				s1         = rand_bits(32);
				s2         = rand_bits(32);
				audio1     = s1;
				audio2     = s2;
				audio_mode = gb2p_cfg_pkg::audio_mode_e'(m);
				@(negedge clk_sys);
				compare("audio_out", model_mix(2'(m), s1, s2), audio_out);
			end
		end
		report_test("audio mixing");

		$display("tests run %0d, tests failed %0d, checks %0d, errors %0d",
			tests_run, tests_failed, check_count, err_count);
		if (err_count == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

//--- gb2p_glue.sv
/*
 * Two-console glue: shared cartridge store, download routing and audio mix.
 * rom_aw must not exceed gb2p_cfg_pkg::rom_aw; addresses are console bytes.
 */
module gb2p_glue #(
	parameter int rom_aw = gb2p_cfg_pkg::rom_aw
) (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  logic                      dl_active,
	input  gb2p_bus_pkg::dl_beat_t    dl,
	input  logic                      rd1,
	input  logic                      rd2,
	input  logic [rom_aw:0]           addr1,
	input  logic [rom_aw:0]           addr2,
	output logic [7:0]                data1,
	output logic [7:0]                data2,
	output logic                      valid1,
	output logic                      valid2,
	output logic                      core_hold,
	input  gb2p_bus_pkg::stereo_t     audio1,
	input  gb2p_bus_pkg::stereo_t     audio2,
	input  gb2p_cfg_pkg::audio_mode_e audio_mode,
	output gb2p_bus_pkg::stereo_t     audio_out,
	output gb2p_bus_pkg::pal_t        palette
);

	logic                  cart_wr_en;
	logic [rom_aw-1:0]     cart_wr_addr;
	logic [15:0]           cart_wr_data;
	gb2p_bus_pkg::wb_req_t req1;
	gb2p_bus_pkg::wb_req_t req2;
	gb2p_bus_pkg::wb_rsp_t rsp1;
	gb2p_bus_pkg::wb_rsp_t rsp2;
	gb2p_bus_pkg::wb_req_t s_req;
	gb2p_bus_pkg::wb_rsp_t s_rsp;

	//////////////////////////////////////////////////////////////////////
	// Download path
	//////////////////////////////////////////////////////////////////////

	download_router #(.rom_aw(rom_aw)) router_i (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.dl_active    (dl_active),
		.dl           (dl),
		.cart_wr_en   (cart_wr_en),
		.cart_wr_addr (cart_wr_addr),
		.cart_wr_data (cart_wr_data),
		.core_hold    (core_hold),
		.palette      (palette)
	);

	rom_store #(.rom_aw(rom_aw)) store_i (
		.clk_sys (clk_sys),
		.reset   (reset),
		.wr_en   (cart_wr_en),
		.wr_addr (cart_wr_addr),
		.wr_data (cart_wr_data),
		.bus_req (s_req),
		.bus_rsp (s_rsp)
	);

	//////////////////////////////////////////////////////////////////////
	// Shared ROM fetch
	//////////////////////////////////////////////////////////////////////

	rom_arbiter #(.rom_aw(rom_aw)) arb_i (
		.clk_sys (clk_sys),
		.reset   (reset),
		.hold    (core_hold),
		.m1_req  (req1),
		.m2_req  (req2),
		.m1_rsp  (rsp1),
		.m2_rsp  (rsp2),
		.s_req   (s_req),
		.s_rsp   (s_rsp)
	);

	cart_rom_port #(.rom_aw(rom_aw)) port1_i (
		.clk_sys (clk_sys),
		.reset   (reset),
		.rd      (rd1),
		.addr    (addr1),
		.data    (data1),
		.valid   (valid1),
		.bus_req (req1),
		.bus_rsp (rsp1)
	);

	cart_rom_port #(.rom_aw(rom_aw)) port2_i (
		.clk_sys (clk_sys),
		.reset   (reset),
		.rd      (rd2),
		.addr    (addr2),
		.data    (data2),
		.valid   (valid2),
		.bus_req (req2),
		.bus_rsp (rsp2)
	);

	// Audio
	audio_mixer mixer_i (
		.clk_sys (clk_sys),
		.reset   (reset),
		.mode    (audio_mode),
		.core1   (audio1),
		.core2   (audio2),
		.mix     (audio_out)
	);

endmodule

//--- audio_mixer.sv
/*
 * Registered stereo mixer of two cores with unsigned 16-bit samples.
 * Halving before the sum keeps the mixed result from overflowing.
 */
module audio_mixer (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  gb2p_cfg_pkg::audio_mode_e mode,
	input  gb2p_bus_pkg::stereo_t     core1,
	input  gb2p_bus_pkg::stereo_t     core2,
	output gb2p_bus_pkg::stereo_t     mix
);

	gb2p_bus_pkg::stereo_t mix_d;
	gb2p_bus_pkg::stereo_t mix_q;

	// Sum of two samples, each shifted down by one
	function automatic logic [15:0] half_sum(input logic [15:0] a, input logic [15:0] b);
		half_sum = {1'b0, a[15:1]} + {1'b0, b[15:1]};
	endfunction

	always_comb begin
		case (mode)
			gb2p_cfg_pkg::mode_core1: mix_d = core1;
			gb2p_cfg_pkg::mode_core2: mix_d = core2;
			gb2p_cfg_pkg::mode_mixed: begin
				mix_d.left  = half_sum(core1.left, core2.left);
				mix_d.right = half_sum(core1.right, core2.right);
			end
			default: begin
				// Split, core 1 mono on the left and core 2 mono on the right
				mix_d.left  = half_sum(core1.left, core1.right);
				mix_d.right = half_sum(core2.left, core2.right);
			end
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			mix_q <= '0;
		end else begin
			mix_q <= mix_d;
		end
	end

	assign mix = mix_q;

endmodule

//--- download_router.sv
/*
 * Splits the host download by index into cartridge writes and palette bytes.
 * Cartridge images larger than the store wrap onto its low words.
 */
module download_router #(
	parameter int rom_aw = gb2p_cfg_pkg::rom_aw
) (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   dl_active,
	input  gb2p_bus_pkg::dl_beat_t dl,
	output logic                   cart_wr_en,
	output logic [rom_aw-1:0]      cart_wr_addr,
	output logic [15:0]            cart_wr_data,
	output logic                   core_hold,
	output gb2p_bus_pkg::pal_t     palette
);

	logic         is_cart;
	logic         is_pal;
	logic         hold_q;
	logic [127:0] pal_q;

	// Index decode
	assign is_cart = (dl.idx == gb2p_cfg_pkg::dl_idx_cart_a) |
	                 (dl.idx == gb2p_cfg_pkg::dl_idx_cart_b) |
	                 (dl.idx == gb2p_cfg_pkg::dl_idx_cart_c);
	assign is_pal  = (dl.idx == gb2p_cfg_pkg::dl_idx_palette);

	// Cartridge beats go straight to the store as word writes
	assign cart_wr_en   = dl_active & dl.wr & is_cart;
	assign cart_wr_addr = dl.addr[rom_aw:1];
	assign cart_wr_data = dl.data;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			hold_q <= 1'b0;
			pal_q  <= gb2p_cfg_pkg::pal_default;
		end else begin
			hold_q <= dl_active & is_cart;
			// Palette file is stored byte swapped
			if (dl_active & dl.wr & is_pal) begin
				pal_q <= {pal_q[111:0], dl.data[7:0], dl.data[15:8]};
			end
		end
	end

	assign core_hold = hold_q;

	// Lowest 32 bits carry no colour
	always_comb begin
		palette.pal1 = pal_q[127:104];
		palette.pal2 = pal_q[103:80];
		palette.pal3 = pal_q[79:56];
		palette.pal4 = pal_q[55:32];
	end

endmodule

//--- cart_rom_port.sv
/*
 * Turns a core's byte read strobe into one Wishbone word read.
 * The core must wait for valid before it strobes rd again.
 */
module cart_rom_port #(
	parameter int rom_aw = gb2p_cfg_pkg::rom_aw
) (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic                  rd,
	input  logic [rom_aw:0]       addr,
	output logic [7:0]            data,
	output logic                  valid,
	output gb2p_bus_pkg::wb_req_t bus_req,
	input  gb2p_bus_pkg::wb_rsp_t bus_rsp
);

	logic            cyc_q;
	logic            valid_q;
	logic [rom_aw:0] addr_q;
	logic [7:0]      data_q;

	// Cycle control
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cyc_q   <= 1'b0;
			valid_q <= 1'b0;
		end else begin
			valid_q <= 1'b0;
			if (rd & ~cyc_q) begin
				cyc_q <= 1'b1;
			end else if (cyc_q & bus_rsp.ack) begin
				cyc_q   <= 1'b0;
				valid_q <= 1'b1;
			end
		end
	end

	// Address and returned byte
	always_ff @(posedge clk_sys) begin
		if (rd & ~cyc_q) begin
			addr_q <= addr;
		end
		if (cyc_q & bus_rsp.ack) begin
			data_q <= bus_req.sel[1] ? bus_rsp.dat[15:8] : bus_rsp.dat[7:0];
		end
	end

	// Word address drops bit 0, which picks the lane
	always_comb begin
		bus_req                  = '0;
		bus_req.cyc              = cyc_q;
		bus_req.stb              = cyc_q;
		bus_req.we               = 1'b0;
		bus_req.adr[rom_aw-1:0]  = addr_q[rom_aw:1];
		bus_req.sel              = addr_q[0] ? 2'b10 : 2'b01;
	end

	assign data  = data_q;
	assign valid = valid_q;

endmodule

//--- rom_arbiter.sv
/*
 * Round-robin arbiter of two Wishbone masters onto the cartridge store.
 * No new grant is given while hold is high; a cycle in flight still completes.
 */
module rom_arbiter #(
	parameter int rom_aw = gb2p_cfg_pkg::rom_aw
) (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic                  hold,
	input  gb2p_bus_pkg::wb_req_t m1_req,
	input  gb2p_bus_pkg::wb_req_t m2_req,
	output gb2p_bus_pkg::wb_rsp_t m1_rsp,
	output gb2p_bus_pkg::wb_rsp_t m2_rsp,
	output gb2p_bus_pkg::wb_req_t s_req,
	input  gb2p_bus_pkg::wb_rsp_t s_rsp
);

	gb2p_cfg_pkg::arb_state_e state_q;

	// High when master 2 holds or last held the grant
	logic last_m2_q;

	logic                  req1;
	logic                  req2;
	logic                  pick_m2;
	logic                  busy;
	gb2p_bus_pkg::wb_req_t granted;

	assign req1 = m1_req.cyc & m1_req.stb;
	assign req2 = m2_req.cyc & m2_req.stb;

	// Master 2 wins when alone, or on a tie after master 1 was served
	assign pick_m2 = req2 & (~req1 | ~last_m2_q);

	assign busy    = (state_q == gb2p_cfg_pkg::arb_busy);
	assign granted = last_m2_q ? m2_req : m1_req;

	//////////////////////////////////////////////////////////////////////
	// Grant FSM
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state_q   <= gb2p_cfg_pkg::arb_idle;
			last_m2_q <= 1'b1;
		end else begin
			case (state_q)
				gb2p_cfg_pkg::arb_idle: begin
					if (~hold & (req1 | req2)) begin
						state_q   <= gb2p_cfg_pkg::arb_busy;
						last_m2_q <= pick_m2;
					end
				end
				gb2p_cfg_pkg::arb_busy: begin
					if (s_rsp.ack) begin
						state_q <= gb2p_cfg_pkg::arb_idle;
					end
				end
				default: begin
					state_q <= gb2p_cfg_pkg::arb_idle;
				end
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Bus routing
	//////////////////////////////////////////////////////////////////////

	// Only the implemented address bits reach the store
	always_comb begin
		s_req = '0;
		if (busy) begin
			s_req.cyc                = granted.cyc;
			s_req.stb                = granted.stb;
			s_req.we                 = granted.we;
			s_req.sel                = granted.sel;
			s_req.adr[rom_aw-1:0]    = granted.adr[rom_aw-1:0];
		end
	end

	// Data is shared, ack goes to the granted master only
	always_comb begin
		m1_rsp.dat = s_rsp.dat;
		m2_rsp.dat = s_rsp.dat;
		m1_rsp.ack = busy & ~last_m2_q & s_rsp.ack;
		m2_rsp.ack = busy & last_m2_q & s_rsp.ack;
	end

endmodule

//--- rom_store.sv
/*
 * On-chip cartridge word store, written by the download and read over Wishbone.
 * Reads and download writes are not expected at the same time.
 */
module rom_store #(
	parameter int rom_aw = gb2p_cfg_pkg::rom_aw
) (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic                  wr_en,
	input  logic [rom_aw-1:0]     wr_addr,
	input  logic [15:0]           wr_data,
	input  gb2p_bus_pkg::wb_req_t bus_req,
	output gb2p_bus_pkg::wb_rsp_t bus_rsp
);

	localparam int depth = 2 ** rom_aw;

	logic [15:0] mem [depth];
	logic        ack_q;
	logic [15:0] dat_q;
	logic        rd_hit;

	// A new read is sampled only when the previous one is not being acked
	assign rd_hit = bus_req.cyc & bus_req.stb & ~bus_req.we & ~ack_q;

	// Download write port
	always_ff @(posedge clk_sys) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= rd_hit;
		end
	end

	// Read data only lives for the ack cycle
	always_ff @(posedge clk_sys) begin
		if (rd_hit) begin
			dat_q <= mem[bus_req.adr[rom_aw-1:0]];
		end else begin
			dat_q <= '0;
		end
	end

	always_comb begin
		bus_rsp.ack = ack_q;
		bus_rsp.dat = dat_q;
	end

endmodule

//--- gb2p_bus_pkg.sv
/*
 * Bundled signals of the glue: ROM bus, download beat, audio and palette.
 * The ROM bus is read only, so the request carries no write data.
 */
package gb2p_bus_pkg;

	// Wishbone classic request from a port master
	typedef struct packed {
		logic                            cyc;
		logic                            stb;
		logic                            we;
		logic [gb2p_cfg_pkg::rom_aw-1:0] adr;
		logic [1:0]                      sel;
	} wb_req_t;

	// Wishbone response, one 16-bit word
	typedef struct packed {
		logic        ack;
		logic [15:0] dat;
	} wb_rsp_t;

	// One beat of the host download stream
	typedef struct packed {
		logic                           wr;
		logic [gb2p_cfg_pkg::dl_aw-1:0] addr;
		logic [15:0]                    data;
		logic [7:0]                     idx;
	} dl_beat_t;

	// Unsigned stereo sample pair
	typedef struct packed {
		logic [15:0] left;
		logic [15:0] right;
	} stereo_t;

	// Four colour entries, pal1 is the top of the palette register
	typedef struct packed {
		logic [23:0] pal1;
		logic [23:0] pal2;
		logic [23:0] pal3;
		logic [23:0] pal4;
	} pal_t;

endpackage

//--- gb2p_cfg_pkg.sv
/*
 * Sizes, download indices and enums shared by the two-console glue.
 * rom_aw here is the widest store that the bus structs can address.
 */
package gb2p_cfg_pkg;

	//////////////////////////////////////////////////////////////////////
	// Widths and depths
	//////////////////////////////////////////////////////////////////////

	// Word address width of the shared cartridge store
	localparam int rom_aw = 10;

	// Byte address width of the host download stream
	localparam int dl_aw = 25;

	//////////////////////////////////////////////////////////////////////
	// Download indices
	//////////////////////////////////////////////////////////////////////

	// Cartridge images (plain, colour and other)
	localparam logic [7:0] dl_idx_cart_a = 8'h01;
	localparam logic [7:0] dl_idx_cart_b = 8'h41;
	localparam logic [7:0] dl_idx_cart_c = 8'h80;

	// Custom palette file
	localparam logic [7:0] dl_idx_palette = 8'h03;

	// Palette after reset, four 24-bit entries from the top down
	localparam logic [127:0] pal_default = 128'h8282_1451_7356_305A_5F1A_3B49_0000_0000;

	//////////////////////////////////////////////////////////////////////
	// Enums
	//////////////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {
		mode_core1 = 2'd0,
		mode_core2 = 2'd1,
		mode_mixed = 2'd2,
		mode_split = 2'd3
	} audio_mode_e;

	typedef enum logic {
		arb_idle = 1'b0,
		arb_busy = 1'b1
	} arb_state_e;

endpackage
